// ==== csc.f ====
design/csc_pkg.sv
design/csc_mul.sv
design/csc_product_stage.sv
design/csc_sum_stage.sv
design/csc_credit_out.sv
design/csc_top.sv
tests/csc_mul_sva.sv
tests/csc_checker.sv
tests/csc_tb.sv

// ==== design/csc_credit_out.sv ====
/* Output buffer with credit flow control: spends sink credits per beat
   and returns one source credit for every beat that leaves */
`timescale 1ns/1ns

module csc_credit_out import csc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      sum_valid,
  input  out_beat_t sum_beat,
  output logic      out_valid,
  output out_beat_t out_beat,
  input  logic      out_credit,
  output logic      in_credit
);

  out_beat_t             mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic [CREDIT_W-1:0]   credit;
  logic                  empty;
  logic                  pop;
  out_beat_t             head;

  assign empty = (count == '0);

  // When empty, the arriving beat goes straight to the output register
  assign head = empty ? sum_beat : mem[rd_ptr];
  assign pop  = (!empty || sum_valid) && (credit != '0);

  // Source credits guarantee room, so every arriving beat is written
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      mem[wr_ptr] <= sum_beat;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= '0;
    end else begin
      if (sum_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({sum_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Grant and spend in one cycle cancel
      case ({out_credit, pop})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= pop;
      in_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_beat <= head;
    end
  end

endmodule

// ==== design/csc_mul.sv ====
/* Sign-magnitude coefficient by unsigned component multiplier
   Radix-4 Booth recode, three register stages, one operand pair per cycle */
`timescale 1ns/1ns

module csc_mul import csc_pkg::*; (
  input  logic       clk,
  input  coef_t      coef,
  input  logic [7:0] comp,
  output prod_t      prod
);

  // Partial product for one Booth window, before its shift
  function automatic logic signed [25:0] booth_pp(input logic [2:0] win,
                                                  input logic [15:0] mag);
    logic signed [25:0] one;
    logic signed [25:0] pp;
    one = $signed({10'd0, mag});
    case (win)
      3'b001, 3'b010: pp = one;
      3'b011:         pp = one <<< 1;
      3'b100:         pp = -(one <<< 1);
      3'b101, 3'b110: pp = -one;
      default:        pp = '0;
    endcase
    return pp;
  endfunction

  logic signed [25:0] pp_d [5];
  logic signed [25:0] pp_q [5];
  logic               sign_q1;
  logic signed [25:0] sum_a_q;
  logic signed [25:0] sum_b_q;
  logic signed [25:0] pp4_q;
  logic               sign_q2;
  logic signed [25:0] total;

  // Four overlapping windows, the lowest with an implied zero below bit 0
  always_comb begin
    pp_d[0] = booth_pp({comp[1:0], 1'b0}, coef.mag);
    pp_d[1] = booth_pp(comp[3:1], coef.mag) <<< 2;
    pp_d[2] = booth_pp(comp[5:3], coef.mag) <<< 4;
    pp_d[3] = booth_pp(comp[7:5], coef.mag) <<< 6;
    // comp is unsigned, so a set top bit needs one more +mag at weight 256
    pp_d[4] = comp[7] ? ($signed({10'd0, coef.mag}) <<< 8) : '0;
  end

  // Stage 1 holds the partial products
  always_ff @(posedge clk) begin
    for (int i = 0; i < 5; i++) begin
      pp_q[i] <= pp_d[i];
    end
    sign_q1 <= coef.sign;
  end

  // Stage 2 adds them in pairs
  always_ff @(posedge clk) begin
    sum_a_q <= pp_q[0] + pp_q[1];
    sum_b_q <= pp_q[2] + pp_q[3];
    pp4_q   <= pp_q[4];
    sign_q2 <= sign_q1;
  end

  // Final sum is mag * comp, never negative and below 2^24
  assign total = sum_a_q + sum_b_q + pp4_q;

  // Stage 3 registers the product
  always_ff @(posedge clk) begin
    prod.sign <= sign_q2;
    prod.mag  <= total[23:0];
  end

endmodule

// ==== design/csc_pkg.sv ====
/* Colour space converter shared types and constants
   Pixel beats, sign-magnitude coefficients, matrix layout and pipeline depths */
package csc_pkg;

  // Pipeline depths
  localparam int MUL_LATENCY = 3;
  localparam int SUM_LATENCY = 2;
  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W    = 4;
  localparam int FRAC_BITS   = 8;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix_t;

  typedef struct packed {
    pix_t pix;
    logic last;   // end of line
  } in_beat_t;

  // One result per matrix row
  typedef struct packed {
    logic [7:0] c0;
    logic [7:0] c1;
    logic [7:0] c2;
  } ycc_t;

  typedef struct packed {
    ycc_t pix;
    logic last;
  } out_beat_t;

  // Magnitude in units of 1/256
  typedef struct packed {
    logic        sign;
    logic [15:0] mag;
  } coef_t;

  // coef[0] scales r, coef[1] g, coef[2] b
  typedef struct packed {
    coef_t [2:0]       coef;
    logic signed [8:0] offset;
  } row_t;

  typedef row_t [2:0] matrix_t;

  typedef struct packed {
    logic        sign;
    logic [23:0] mag;
  } prod_t;

  typedef struct packed {
    logic valid;
    logic last;
  } ctl_t;

endpackage

// ==== design/csc_product_stage.sv ====
/* Product stage: nine multipliers, one per matrix coefficient,
   with valid and last delayed to match the multiplier latency */
`timescale 1ns/1ns

module csc_product_stage import csc_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  matrix_t          matrix,
  input  logic             in_valid,
  input  in_beat_t         in_beat,
  output prod_t [2:0][2:0] prods,
  output ctl_t             ctl
);

  logic [2:0][7:0]             comp;
  ctl_t                        ctl_in;
  ctl_t [MUL_LATENCY-1:0]      ctl_sr;

  // Column order r, g, b
  assign comp[0] = in_beat.pix.r;
  assign comp[1] = in_beat.pix.g;
  assign comp[2] = in_beat.pix.b;

  for (genvar row = 0; row < 3; row++) begin : g_row
    for (genvar col = 0; col < 3; col++) begin : g_col
      csc_mul i_csc_mul (
        .clk  (clk),
        .coef (matrix[row].coef[col]),
        .comp (comp[col]),
        .prod (prods[row][col])
      );
    end
  end

  assign ctl_in.valid = in_valid;
  assign ctl_in.last  = in_beat.last;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl_sr <= '0;
    end else begin
      ctl_sr <= {ctl_sr[MUL_LATENCY-2:0], ctl_in};
    end
  end

  assign ctl = ctl_sr[MUL_LATENCY-1];

endmodule

// ==== design/csc_sum_stage.sv ====
/* Sum stage: adds each row's products and offset, then floors,
   scales back to integer and clamps to 0..255 */
`timescale 1ns/1ns

module csc_sum_stage import csc_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  matrix_t          matrix,
  input  prod_t [2:0][2:0] prods,
  input  ctl_t             ctl,
  output logic             sum_valid,
  output out_beat_t        sum_beat
);

  // Sign-magnitude product to two's complement
  function automatic logic signed [27:0] to_signed(input prod_t p);
    logic signed [27:0] m;
    m = $signed({4'd0, p.mag});
    return p.sign ? -m : m;
  endfunction

  // Arithmetic shift floors, then saturate
  function automatic logic [7:0] clamp8(input logic signed [27:0] acc);
    logic signed [27:0] s;
    s = acc >>> FRAC_BITS;
    if (s < 0) begin
      return 8'd0;
    end else if (s > 255) begin
      return 8'd255;
    end
    return s[7:0];
  endfunction

  logic signed [27:0]     off_s [3];
  logic signed [27:0]     acc_d [3];
  logic signed [27:0]     acc_q [3];
  ctl_t [SUM_LATENCY-1:0] ctl_sr;

  always_comb begin
    for (int r = 0; r < 3; r++) begin
      off_s[r] = $signed({{19{matrix[r].offset[8]}}, matrix[r].offset}) <<< FRAC_BITS;
      acc_d[r] = to_signed(prods[r][0]) + to_signed(prods[r][1])
               + to_signed(prods[r][2]) + off_s[r];
    end
  end

  // Cycle 1: row sums
  always_ff @(posedge clk) begin
    for (int r = 0; r < 3; r++) begin
      acc_q[r] <= acc_d[r];
    end
  end

  // Cycle 2: scaled and clamped results
  always_ff @(posedge clk) begin
    sum_beat.pix.c0 <= clamp8(acc_q[0]);
    sum_beat.pix.c1 <= clamp8(acc_q[1]);
    sum_beat.pix.c2 <= clamp8(acc_q[2]);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl_sr <= '0;
    end else begin
      ctl_sr <= {ctl_sr[SUM_LATENCY-2:0], ctl};
    end
  end

  assign sum_valid     = ctl_sr[SUM_LATENCY-1].valid;
  assign sum_beat.last = ctl_sr[SUM_LATENCY-1].last;

endmodule

// ==== design/csc_top.sv ====
/* Colour space converter top: product, sum and credit output stages */
`timescale 1ns/1ns

module csc_top import csc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  matrix_t   matrix,
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  output logic      in_credit,
  output logic      out_valid,
  output out_beat_t out_beat,
  input  logic      out_credit
);

  prod_t [2:0][2:0] prods;
  ctl_t             ctl;
  logic             sum_valid;
  out_beat_t        sum_beat;

  csc_product_stage i_csc_product_stage (
    .clk      (clk),
    .arst_n   (arst_n),
    .matrix   (matrix),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .prods    (prods),
    .ctl      (ctl)
  );

  csc_sum_stage i_csc_sum_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .matrix    (matrix),
    .prods     (prods),
    .ctl       (ctl),
    .sum_valid (sum_valid),
    .sum_beat  (sum_beat)
  );

  csc_credit_out i_csc_credit_out (
    .clk        (clk),
    .arst_n     (arst_n),
    .sum_valid  (sum_valid),
    .sum_beat   (sum_beat),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_credit (out_credit),
    .in_credit  (in_credit)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the converter testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module csc_tb \
  -f csc.f --Mdir obj_dir -o csc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/csc_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// ==== tests/csc_checker.sv ====
/* Scoreboard for the converter: reference model, expected queue,
   data and credit checks */
`timescale 1ns/1ns

module csc_checker import csc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  matrix_t   matrix,
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  input  logic      in_credit,
  input  logic      out_valid,
  input  out_beat_t out_beat,
  input  logic      out_credit,
  input  int        test_id,
  input  logic      done,
  output int        error_total
);

  out_beat_t exp_q [$];
  int data_errors = 0;
  int credit_errors = 0;
  int checked = 0;
  int sink_credits = 0;
  int src_credits = FIFO_DEPTH;

  function automatic string test_name(input int id);
    case (id)
      1: return "reset";
      2: return "identity";
      3: return "ycbcr";
      4: return "random_matrix";
      5: return "backpressure";
      default: return "unknown";
    endcase
  endfunction

  // Row sum with offset, floored over 256 and saturated to a byte
  function automatic out_beat_t expected_beat(input matrix_t m, input in_beat_t b);
    out_beat_t  e;
    int         comp [3];
    int         acc;
    logic [7:0] res [3];
    comp[0] = int'(b.pix.r);
    comp[1] = int'(b.pix.g);
    comp[2] = int'(b.pix.b);
    for (int r = 0; r < 3; r++) begin
      acc = int'(m[r].offset) * 256;
      for (int c = 0; c < 3; c++) begin
        if (m[r].coef[c].sign) acc -= int'(m[r].coef[c].mag) * comp[c];
        else acc += int'(m[r].coef[c].mag) * comp[c];
      end
      acc = acc >>> FRAC_BITS;
      res[r] = (acc < 0) ? 8'd0 : (acc > 255) ? 8'd255 : 8'(acc);
    end
    e.pix.c0 = res[0];
    e.pix.c1 = res[1];
    e.pix.c2 = res[2];
    e.last   = b.last;
    return e;
  endfunction

  always @(posedge clk) begin
    out_beat_t want;
    if (!arst_n) begin
      if (out_valid || in_credit) begin
        $display("Output valid or input credit is set during reset");
        credit_errors++;
      end
      exp_q.delete();
      sink_credits = 0;
      src_credits = FIFO_DEPTH;
    end else begin
      if (in_valid) begin
        exp_q.push_back(expected_beat(matrix, in_beat));
      end
      if (out_valid) begin
        if (sink_credits == 0) begin
          $display("Output beat sent without a sink credit");
          credit_errors++;
        end
        if (exp_q.size() == 0) begin
          $display("Output beat arrived when no beat was expected");
          data_errors++;
        end else begin
          want = exp_q.pop_front();
          checked++;
          if (out_beat !== want) begin
            $display("** Error [%s] expected %h actual %h", test_name(test_id), want, out_beat);
            data_errors++;
          end
        end
      end
      if (in_credit != out_valid) begin
        $display("Input credit pulse does not match an output beat");
        credit_errors++;
      end
      if (out_credit) sink_credits++;
      if (out_valid) sink_credits--;
      if (in_credit) src_credits++;
      if (in_valid) src_credits--;
      if (src_credits > FIFO_DEPTH) begin
        $display("More input credits were returned than beats were sent");
        credit_errors++;
      end
    end
  end

  always @(posedge done) begin
    $display("Checked %0d beats, %0d data errors, %0d credit errors, %0d beats outstanding",
             checked, data_errors, credit_errors, exp_q.size());
  end

  assign error_total = data_errors + credit_errors;

endmodule

// ==== tests/csc_mul_sva.sv ====
/* Multiplier assertions: product value and latency, unknowns on operands and product */
`timescale 1ns/1ns

module csc_mul_sva import csc_pkg::*; (
  input logic       clk,
  input coef_t      coef,
  input logic [7:0] comp,
  input prod_t      prod
);

  logic [1:0] warm = 2'd0;

  // Counts edges until the pipeline holds real operands
  always_ff @(posedge clk) begin
    if (warm != 2'(MUL_LATENCY)) begin
      warm <= warm + 2'd1;
    end
  end

  a_prod_value: assert property (@(posedge clk)
    warm == 2'(MUL_LATENCY) |->
      prod.sign == $past(coef.sign, MUL_LATENCY) &&
      prod.mag == 24'($past(coef.mag, MUL_LATENCY)) * 24'($past(comp, MUL_LATENCY)))
    else $error("Product does not match the operands of three cycles earlier");

  a_operands_known: assert property (@(posedge clk) !$isunknown({coef, comp}))
    else $error("Multiplier operands hold unknown bits");

  a_prod_known: assert property (@(posedge clk)
    warm == 2'(MUL_LATENCY) |-> !$isunknown(prod))
    else $error("Multiplier product holds unknown bits");

endmodule

bind csc_mul csc_mul_sva i_csc_mul_sva (
  .clk  (clk),
  .coef (coef),
  .comp (comp),
  .prod (prod)
);

// ==== tests/csc_tb.sv ====
/* Converter testbench: clock, reset, credit-limited source,
   sink credit policy and the test sequence */
`timescale 1ns/1ns

module csc_tb import csc_pkg::*; ();

  localparam int TIMEOUT = 2000;

  logic      clk;
  logic      arst_n;
  matrix_t   matrix;
  logic      in_valid;
  in_beat_t  in_beat;
  logic      in_credit;
  logic      out_valid;
  out_beat_t out_beat;
  logic      out_credit;
  int        test_id;
  logic      done;
  int        error_total;

  integer seed = 32'h59af5a78;
  integer sink_seed = 32'h59af5a78;
  int     sent = 0;
  int     returned = 0;
  int     granted = 0;
  int     received = 0;
  int     sink_mode = 0;   // 0 no grants, 1 every cycle, 2 sparse with bursts
  int     burst_left = 0;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  csc_top i_csc_top (.*);

  csc_checker i_csc_checker (.*);

  always @(posedge clk) begin
    if (in_credit) returned++;
    if (out_valid) received++;
  end

  function automatic logic bursty_grant();
    int r;
    r = $random(sink_seed) & 31;
    if (burst_left > 0) begin
      burst_left--;
      return 1'b1;
    end
    if (r == 0) burst_left = 4 + ($random(sink_seed) & 7);
    return r == 1;
  endfunction

  // Sink never has more than 15 credits outstanding
  initial begin
    logic grant;
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      grant = 1'b0;
      if (granted - received < 15) begin
        grant = (sink_mode == 1) || (sink_mode == 2 && bursty_grant());
      end
      out_credit = grant;
      if (grant) granted++;
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while %s", what);
    done = 1'b1;
    #1;
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic send_pixel(input pix_t pix, input logic last);
    int waited;
    waited = 0;
    while (FIFO_DEPTH - sent + returned == 0) begin
      @(posedge clk);
      #10;
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("waiting for an input credit");
    end
    in_valid = 1'b1;
    in_beat.pix = pix;
    in_beat.last = last;
    sent++;
    @(posedge clk);
    #10;
    in_valid = 1'b0;
    if (($random(seed) & 3) == 0) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic send_random(input int n);
    logic [31:0] v;
    for (int i = 0; i < n; i++) begin
      v = $random(seed);
      send_pixel(v[23:0], (i % 8) == 7);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (sent != received) begin
      @(posedge clk);
      #10;
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("waiting for the pipeline to drain");
    end
  endtask

  function automatic coef_t to_coef(input int k);
    coef_t c;
    c.sign = (k < 0);
    c.mag  = 16'(k < 0 ? -k : k);
    return c;
  endfunction

  function automatic row_t make_row(input int k0, input int k1, input int k2, input int off);
    row_t row;
    row.coef[0] = to_coef(k0);
    row.coef[1] = to_coef(k1);
    row.coef[2] = to_coef(k2);
    row.offset  = 9'(off);
    return row;
  endfunction

  // Magnitudes shifted down by 0, 4, 8 or 12 bits so both small and huge ones occur
  function automatic matrix_t random_matrix();
    matrix_t     m;
    logic [31:0] v;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        v = $random(seed);
        m[r].coef[c].sign = v[31];
        m[r].coef[c].mag  = v[15:0] >> {v[21:20], 2'b00};
      end
      v = $random(seed);
      m[r].offset = v[8:0];
    end
    return m;
  endfunction

  initial begin
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    done     = 1'b0;
    test_id  = 1;
    matrix   = {make_row(0, 0, 256, 0), make_row(0, 256, 0, 0), make_row(256, 0, 0, 0)};
    repeat (16) @(posedge clk);
    #10;
    arst_n = 1'b1;

    // Beats must stay in the buffer until the sink grants credits
    send_random(4);
    repeat (30) @(posedge clk);
    #10;
    sink_mode = 1;
    wait_drain();

    test_id = 2;
    send_random(40);
    wait_drain();

    test_id = 3;
    matrix = {make_row(112, -94, -18, 128), make_row(-38, -74, 112, 128),
              make_row(66, 129, 25, 16)};
    send_pixel(24'h000000, 1'b0);
    send_pixel(24'hffffff, 1'b0);
    send_pixel(24'hff0000, 1'b0);
    send_pixel(24'h00ff00, 1'b0);
    send_pixel(24'h0000ff, 1'b1);
    send_random(30);
    wait_drain();

    test_id = 4;
    repeat (6) begin
      matrix = random_matrix();
      send_random(24);
      wait_drain();
    end

    test_id = 5;
    sink_mode = 2;
    send_random(120);
    wait_drain();

    done = 1'b1;
    #1;
    if (error_total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
